//--- cpu12_backend.f
source/cpu12_pkg.sv
source/stage_if.sv
source/mem_if.sv
source/exec_stage.sv
source/mem_stage.sv
source/data_ram.sv
source/cpu12_backend.sv
verif/cpu12_backend_checker.sv
verif/tb_cpu12_backend.sv

//--- Makefile
SIM      := verilator
TOP      := tb_cpu12_backend
FILELIST := cpu12_backend.f
FLAGS    := --binary --timing --assert -j 0
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- verif/tb_cpu12_backend.sv
// Random traffic against a two-entry model pipeline; every RAM word is stored before the first load
`timescale 1ns/1ps
`default_nettype none

module tb_cpu12_backend;

    localparam int W       = cpu12_pkg::WORD_W;
    localparam int AW      = 6;
    localparam int TIMEOUT = 50;

    typedef struct packed {
        logic         valid;
        logic [W-1:0] pc;
        logic [W-1:0] instr;
        logic [3:0]   set;
        logic [W-1:0] sdata;
        logic [W-1:0] result;
        logic [3:0]   flags;
    } entry_t;

    logic             clk         = 1'b0;
    logic             rst         = 1'b1;
    logic             advance     = 1'b0;
    logic             issue_valid = 1'b0;
    logic             stall_en    = 1'b0;
    logic [W-1:0]     pc          = '0;
    logic [W-1:0]     instr       = '0;
    logic [W-1:0]     op_a        = '0;
    logic [W-1:0]     op_b        = '0;
    logic [W-1:0]     store_data  = '0;
    cpu12_pkg::iset_e instr_set   = cpu12_pkg::ISET_R;
    logic [W-1:0]     wb_pc;
    logic [W-1:0]     wb_instr;
    logic [W-1:0]     wb_result;
    logic [3:0]       wb_flags;
    cpu12_pkg::iset_e wb_set;
    logic [W-1:0]     model_ram [0:2**AW-1];
    entry_t           pipe [0:1];
    entry_t           nxt;
    int               seed        = 32'h362d_93db;
    int               issued      = 0;
    int               retired     = 0;
    string            test_name   = "reset";

    cpu12_backend #(.MEM_ADDR_W(AW)) i_dut (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    // Expected {result, flags} from the ALU and address rules
    function automatic logic [W+3:0] alu_model(input logic [3:0] set, input logic [W-1:0] ins,
                                               input logic [W-1:0] a, input logic [W-1:0] b);
        int           ia;
        int           ib;
        int           sa;
        int           sb;
        int           r;
        logic [W-1:0] res;
        logic [3:0]   f;
        logic         zn;
        ia = int'(a);
        ib = (set == cpu12_pkg::ISET_I) ? int'(ins[7:0]) : int'(b);
        sa = (ia >= 2048) ? ia - 4096 : ia;
        sb = (ib >= 2048) ? ib - 4096 : ib;
        r  = 0;
        f  = '0;
        zn = 1'b1;
        case ({set, ins[11:8]})
            {cpu12_pkg::ISET_R, cpu12_pkg::OPC_R_ADD}, {cpu12_pkg::ISET_I, cpu12_pkg::OPC_I_ADDI}: begin
                r = ia + ib;
                f[cpu12_pkg::FLAG_C] = r > 4095;
                f[cpu12_pkg::FLAG_V] = (sa + sb > 2047) || (sa + sb < -2048);
            end
            {cpu12_pkg::ISET_R, cpu12_pkg::OPC_R_SUB}: begin
                r = ia - ib;
                f[cpu12_pkg::FLAG_C] = ia >= ib;
                f[cpu12_pkg::FLAG_V] = (sa - sb > 2047) || (sa - sb < -2048);
            end
            {cpu12_pkg::ISET_R, cpu12_pkg::OPC_R_AND}, {cpu12_pkg::ISET_I, cpu12_pkg::OPC_I_ANDI}:
                r = ia & ib;
            {cpu12_pkg::ISET_R, cpu12_pkg::OPC_R_OR}:  r = ia | ib;
            {cpu12_pkg::ISET_R, cpu12_pkg::OPC_R_XOR}: r = ia ^ ib;
            {cpu12_pkg::ISET_R, cpu12_pkg::OPC_R_LD}, {cpu12_pkg::ISET_R, cpu12_pkg::OPC_R_ST},
            {cpu12_pkg::ISET_I, cpu12_pkg::OPC_I_LDI}, {cpu12_pkg::ISET_I, cpu12_pkg::OPC_I_STI}: begin
                r  = (ia + ib) % (2 ** AW);
                zn = 1'b0;
            end
            default: zn = 1'b0;
        endcase
        res = r[W-1:0];
        f[cpu12_pkg::FLAG_Z] = zn && (res == '0);
        f[cpu12_pkg::FLAG_N] = zn && res[W-1];
        return {res, f};
    endfunction

    // 2'b01 for a load, 2'b10 for a store
    function automatic logic [1:0] mem_kind(input logic [3:0] set, input logic [W-1:0] ins);
        logic [7:0] key;
        key = {set, ins[11:8]};
        if (key == {cpu12_pkg::ISET_R, cpu12_pkg::OPC_R_LD} ||
            key == {cpu12_pkg::ISET_I, cpu12_pkg::OPC_I_LDI}) return 2'b01;
        if (key == {cpu12_pkg::ISET_R, cpu12_pkg::OPC_R_ST} ||
            key == {cpu12_pkg::ISET_I, cpu12_pkg::OPC_I_STI}) return 2'b10;
        return 2'b00;
    endfunction

    task automatic check(input string what, input logic [W-1:0] expected,
                         input logic [W-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s %s expected %03h actual %03h",
                     test_name, what, expected, actual);
            $display("=== FAIL ===");
            $fatal(1, "%s: %s mismatch", test_name, what);
        end
    endtask

    // Model pipeline, shifts only on advance edges
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            pipe[0] <= '0;
            pipe[1] <= '0;
            retired <= 0;
        end else if (advance) begin
            nxt = pipe[0];
            if (mem_kind(nxt.set, nxt.instr) == 2'b10) begin
                model_ram[nxt.result[AW-1:0]] = nxt.sdata;
            end else if (mem_kind(nxt.set, nxt.instr) == 2'b01) begin
                nxt.result = model_ram[nxt.result[AW-1:0]];
            end
            pipe[1] <= nxt;
            pipe[0] <= {issue_valid, pc, instr, instr_set, store_data,
                        alu_model(instr_set, instr, op_a, op_b)};
            if (pipe[0].valid) retired <= retired + 1;
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            check("wb_pc", pipe[1].pc, wb_pc);
            check("wb_instr", pipe[1].instr, wb_instr);
            check("wb_set", {8'h0, pipe[1].set}, {8'h0, wb_set});
            check("wb_result", pipe[1].result, wb_result);
            check("wb_flags", {8'h0, pipe[1].flags}, {8'h0, wb_flags});
        end
    end

    // Optional stall gaps with junk inputs, then one advance edge for the instruction
    task automatic issue(input logic [3:0] set, input logic [W-1:0] ins,
                         input logic [W-1:0] a, input logic [W-1:0] b, input logic [W-1:0] sd);
        int          gaps;
        logic [31:0] r;
        gaps = 0;
        while (stall_en && gaps < 4 && rand_word() % 3 == 0) begin
            @(negedge clk);
            r           = rand_word();
            advance     = 1'b0;
            issue_valid = 1'b0;
            instr       = r[W-1:0];
            op_a        = r[31:20];
            gaps++;
        end
        @(negedge clk);
        advance     = 1'b1;
        issue_valid = 1'b1;
        instr_set   = cpu12_pkg::iset_e'(set);
        instr       = ins;
        op_a        = a;
        op_b        = b;
        store_data  = sd;
        pc          = pc + 12'd1;
        issued++;
    endtask

    // NOP bubbles until the model has retired every issued instruction
    task automatic drain();
        int n;
        n = 0;
        while (retired != issued && n < TIMEOUT) begin
            @(negedge clk);
            advance     = 1'b1;
            issue_valid = 1'b0;
            instr_set   = cpu12_pkg::ISET_R;
            instr       = '0;
            n++;
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            check("reset_wb", '0, wb_pc | wb_instr | wb_result | {4'h0, wb_set, wb_flags});
        end

        test_name = "ram_fill";
        for (int i = 0; i < 2 ** AW; i++) begin
            r = rand_word();
            issue(cpu12_pkg::ISET_R, {cpu12_pkg::OPC_R_ST, r[7:0]}, 12'(i), {r[31:26], 6'd0},
                  r[27:16]);
        end

        test_name = "r_alu";
        for (int i = 0; i < 80; i++) begin
            r  = rand_word();
            r2 = rand_word();
            // Equal operands now and then to reach the zero flag
            issue(cpu12_pkg::ISET_R, {4'(1 + r2[31:16] % 5), r2[7:0]}, r[11:0],
                  (r[31:30] == 2'b00) ? r[11:0] : r[23:12], r2[27:16]);
        end

        test_name = "i_imm";
        for (int i = 0; i < 40; i++) begin
            r  = rand_word();
            r2 = rand_word();
            issue(cpu12_pkg::ISET_I,
                  {r2[0] ? cpu12_pkg::OPC_I_ANDI : cpu12_pkg::OPC_I_ADDI, r[7:0]},
                  r[23:12], r2[27:16], r2[15:4]);
        end

        test_name = "store_load";
        for (int i = 0; i < 30; i++) begin
            r  = rand_word();
            r2 = rand_word();
            if (r[0]) begin
                issue(cpu12_pkg::ISET_R, {cpu12_pkg::OPC_R_ST, r[15:8]}, r2[11:0], r2[23:12],
                      r[27:16]);
                issue(cpu12_pkg::ISET_R, {cpu12_pkg::OPC_R_LD, r[15:8]}, r2[11:0], r2[23:12],
                      12'h0);
            end else begin
                issue(cpu12_pkg::ISET_I, {cpu12_pkg::OPC_I_STI, r[15:8]}, r2[11:0], 12'h0,
                      r[27:16]);
                issue(cpu12_pkg::ISET_I, {cpu12_pkg::OPC_I_LDI, r[15:8]}, r2[11:0], r2[23:12],
                      12'h0);
            end
        end

        test_name = "mixed_stall";
        stall_en  = 1'b1;
        for (int i = 0; i < 300; i++) begin
            r  = rand_word();
            r2 = rand_word();
            issue({3'b0, r[4]}, r[31:20], r2[11:0], r2[23:12], {r2[31:24], r[3:0]});
        end

        drain();
        // One more edge so the last writeback is compared on its falling edge
        @(posedge clk);
        if (retired != issued) begin
            $display("Pipeline did not drain, %0d of %0d instructions retired", retired, issued);
            $display("=== FAIL ===");
            $fatal(1, "drain timeout");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verif/cpu12_backend_checker.sv
// Bound into cpu12_backend; reaches the RAM write enable through the ram_bus instance inside the top
`timescale 1ns/1ps
`default_nettype none

module cpu12_backend_checker (
    input logic                         clk,
    input logic                         rst,
    input logic                         advance,
    input logic                         we,
    input logic [cpu12_pkg::WORD_W-1:0] wb_pc,
    input logic [cpu12_pkg::WORD_W-1:0] wb_instr,
    input logic [3:0]                   wb_set,
    input logic [cpu12_pkg::WORD_W-1:0] wb_result,
    input logic [cpu12_pkg::FLAG_W-1:0] wb_flags
);

    a_wb_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({wb_pc, wb_instr, wb_set, wb_result, wb_flags}))
        else $error("writeback output is unknown after reset");

    // A held pipeline keeps its writeback latch
    a_wb_hold: assert property (@(posedge clk) disable iff (rst)
        !advance |=> $stable({wb_pc, wb_instr, wb_set, wb_result, wb_flags}))
        else $error("writeback output changed while advance was low");

    a_we_advance: assert property (@(posedge clk) disable iff (rst) we |-> advance)
        else $error("RAM write enable high without advance");

endmodule

bind cpu12_backend cpu12_backend_checker i_checker (
    .clk      (clk),
    .rst      (rst),
    .advance  (advance),
    .we       (ram_bus.we),
    .wb_pc    (wb_pc),
    .wb_instr (wb_instr),
    .wb_set   (wb_set),
    .wb_result(wb_result),
    .wb_flags (wb_flags)
);

`default_nettype wire

//--- source/cpu12_backend.sv
// Back end top; one global advance stalls everything, and results retire two advance edges after entry
`timescale 1ns/1ps
`default_nettype none

module cpu12_backend #(
    parameter int MEM_ADDR_W = 6
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         advance,
    input  logic [cpu12_pkg::WORD_W-1:0] pc,
    input  logic [cpu12_pkg::WORD_W-1:0] instr,
    input  cpu12_pkg::iset_e             instr_set,
    input  logic [cpu12_pkg::WORD_W-1:0] op_a,
    input  logic [cpu12_pkg::WORD_W-1:0] op_b,
    input  logic [cpu12_pkg::WORD_W-1:0] store_data,
    output logic [cpu12_pkg::WORD_W-1:0] wb_pc,
    output logic [cpu12_pkg::WORD_W-1:0] wb_instr,
    output cpu12_pkg::iset_e             wb_set,
    output logic [cpu12_pkg::WORD_W-1:0] wb_result,
    output logic [cpu12_pkg::FLAG_W-1:0] wb_flags
);

    // Execute latch contents toward the memory stage
    stage_if ex_to_mem ();

    mem_if #(.MEM_ADDR_W(MEM_ADDR_W)) ram_bus ();

    exec_stage #(.MEM_ADDR_W(MEM_ADDR_W)) i_exec (
        .clk       (clk),
        .rst       (rst),
        .advance   (advance),
        .pc        (pc),
        .instr     (instr),
        .instr_set (instr_set),
        .op_a      (op_a),
        .op_b      (op_b),
        .store_data(store_data),
        .out       (ex_to_mem.src)
    );

    mem_stage i_mem (
        .clk      (clk),
        .rst      (rst),
        .advance  (advance),
        .in       (ex_to_mem.dst),
        .mem      (ram_bus.ctrl),
        .wb_pc    (wb_pc),
        .wb_instr (wb_instr),
        .wb_result(wb_result),
        .wb_set   (wb_set),
        .wb_flags (wb_flags)
    );

    data_ram #(.MEM_ADDR_W(MEM_ADDR_W)) i_ram (
        .clk(clk),
        .bus(ram_bus.ram)
    );

endmodule

`default_nettype wire

//--- source/data_ram.sv
// Data RAM of 2**MEM_ADDR_W words; contents are unknown after power-up, so store before loading
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int MEM_ADDR_W = 6
) (
    input  logic clk,
    mem_if.ram   bus
);

    localparam int DEPTH = 2 ** MEM_ADDR_W;

    logic [cpu12_pkg::WORD_W-1:0] mem_array [0:DEPTH-1];

    // Read is combinational so a load finishes in one stage
    assign bus.rdata = mem_array[bus.addr];

    always_ff @(posedge clk) begin
        if (bus.we) begin
            mem_array[bus.addr] <= bus.wdata;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_stage.sv
// Memory stage; a store writes only on an advance edge, and a load sees data written at an earlier edge
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         advance,
    stage_if.dst                         in,
    mem_if.ctrl                          mem,
    output logic [cpu12_pkg::WORD_W-1:0] wb_pc,
    output logic [cpu12_pkg::WORD_W-1:0] wb_instr,
    output logic [cpu12_pkg::WORD_W-1:0] wb_result,
    output cpu12_pkg::iset_e             wb_set,
    output logic [cpu12_pkg::FLAG_W-1:0] wb_flags
);

    localparam int ADDR_W = $bits(mem.addr);

    cpu12_pkg::opc_r_e            opc_r;
    cpu12_pkg::opc_i_e            opc_i;
    logic                         is_load;
    logic                         is_store;
    logic [cpu12_pkg::WORD_W-1:0] stage_result;

    assign opc_r = cpu12_pkg::opc_r_e'(in.instr[11:8]);
    assign opc_i = cpu12_pkg::opc_i_e'(in.instr[11:8]);

    // Load/store decode over both instruction sets
    assign is_load  = ((in.iset == cpu12_pkg::ISET_R) && (opc_r == cpu12_pkg::OPC_R_LD)) ||
                      ((in.iset == cpu12_pkg::ISET_I) && (opc_i == cpu12_pkg::OPC_I_LDI));
    assign is_store = ((in.iset == cpu12_pkg::ISET_R) && (opc_r == cpu12_pkg::OPC_R_ST)) ||
                      ((in.iset == cpu12_pkg::ISET_I) && (opc_i == cpu12_pkg::OPC_I_STI));

    // Address already wrapped in execute
    assign mem.addr  = in.result[ADDR_W-1:0];
    assign mem.wdata = in.store_data;
    assign mem.we    = advance && is_store;

    // Loads retire the RAM word, everything else keeps the execute result
    assign stage_result = is_load ? mem.rdata : in.result;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_pc     <= '0;
            wb_instr  <= '0;
            wb_set    <= cpu12_pkg::ISET_R;
            wb_result <= '0;
            wb_flags  <= '0;
        end else if (advance) begin
            wb_pc     <= in.pc;
            wb_instr  <= in.instr;
            wb_set    <= in.iset;
            wb_result <= stage_result;
            wb_flags  <= in.flags;
        end
    end

endmodule

`default_nettype wire

//--- source/exec_stage.sv
// Execute stage; no forwarding, operands must arrive ready, and the latch moves only when advance is high
`timescale 1ns/1ps
`default_nettype none

module exec_stage #(
    parameter int MEM_ADDR_W = 6
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         advance,
    input  logic [cpu12_pkg::WORD_W-1:0] pc,
    input  logic [cpu12_pkg::WORD_W-1:0] instr,
    input  cpu12_pkg::iset_e             instr_set,
    input  logic [cpu12_pkg::WORD_W-1:0] op_a,
    input  logic [cpu12_pkg::WORD_W-1:0] op_b,
    input  logic [cpu12_pkg::WORD_W-1:0] store_data,
    stage_if.src                         out
);

    localparam int W = cpu12_pkg::WORD_W;

    cpu12_pkg::opc_r_e            opc_r;
    cpu12_pkg::opc_i_e            opc_i;
    logic [W-1:0]                 opnd_b;
    logic [W:0]                   sum_ext;
    logic [W:0]                   diff_ext;
    logic                         add_ovf;
    logic                         sub_ovf;
    logic [W-1:0]                 addr_word;
    logic [W-1:0]                 alu_result;
    logic [cpu12_pkg::FLAG_W-1:0] alu_flags;
    logic                         carry;
    logic                         ovf;
    logic                         set_zn;

    assign opc_r = cpu12_pkg::opc_r_e'(instr[11:8]);
    assign opc_i = cpu12_pkg::opc_i_e'(instr[11:8]);

    // I set takes the zero-extended 8-bit immediate
    assign opnd_b = (instr_set == cpu12_pkg::ISET_I) ? {4'b0, instr[7:0]} : op_b;

    assign sum_ext  = {1'b0, op_a} + {1'b0, opnd_b};
    assign diff_ext = {1'b0, op_a} - {1'b0, opnd_b};
    assign add_ovf  = (op_a[W-1] == opnd_b[W-1]) && (sum_ext[W-1] != op_a[W-1]);
    assign sub_ovf  = (op_a[W-1] != opnd_b[W-1]) && (diff_ext[W-1] != op_a[W-1]);

    // Effective address wraps inside the RAM
    assign addr_word = {{(W-MEM_ADDR_W){1'b0}}, sum_ext[MEM_ADDR_W-1:0]};

    always_comb begin
        alu_result = '0;
        carry      = 1'b0;
        ovf        = 1'b0;
        set_zn     = 1'b0;
        case (instr_set)
            cpu12_pkg::ISET_R: begin
                case (opc_r)
                    cpu12_pkg::OPC_R_ADD: begin
                        alu_result = sum_ext[W-1:0];
                        carry      = sum_ext[W];
                        ovf        = add_ovf;
                        set_zn     = 1'b1;
                    end
                    cpu12_pkg::OPC_R_SUB: begin
                        alu_result = diff_ext[W-1:0];
                        // Carry means no borrow
                        carry      = ~diff_ext[W];
                        ovf        = sub_ovf;
                        set_zn     = 1'b1;
                    end
                    cpu12_pkg::OPC_R_AND: begin
                        alu_result = op_a & opnd_b;
                        set_zn     = 1'b1;
                    end
                    cpu12_pkg::OPC_R_OR: begin
                        alu_result = op_a | opnd_b;
                        set_zn     = 1'b1;
                    end
                    cpu12_pkg::OPC_R_XOR: begin
                        alu_result = op_a ^ opnd_b;
                        set_zn     = 1'b1;
                    end
                    cpu12_pkg::OPC_R_LD, cpu12_pkg::OPC_R_ST: alu_result = addr_word;
                    default: alu_result = '0;
                endcase
            end
            cpu12_pkg::ISET_I: begin
                case (opc_i)
                    cpu12_pkg::OPC_I_ADDI: begin
                        alu_result = sum_ext[W-1:0];
                        carry      = sum_ext[W];
                        ovf        = add_ovf;
                        set_zn     = 1'b1;
                    end
                    cpu12_pkg::OPC_I_ANDI: begin
                        alu_result = op_a & opnd_b;
                        set_zn     = 1'b1;
                    end
                    cpu12_pkg::OPC_I_LDI, cpu12_pkg::OPC_I_STI: alu_result = addr_word;
                    default: alu_result = '0;
                endcase
            end
            default: alu_result = '0;
        endcase

        alu_flags                   = '0;
        alu_flags[cpu12_pkg::FLAG_Z] = set_zn && (alu_result == '0);
        alu_flags[cpu12_pkg::FLAG_N] = set_zn && alu_result[W-1];
        alu_flags[cpu12_pkg::FLAG_C] = carry;
        alu_flags[cpu12_pkg::FLAG_V] = ovf;
    end

    // Execute latch, cleared to a NOP bubble
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out.pc         <= '0;
            out.instr      <= '0;
            out.iset       <= cpu12_pkg::ISET_R;
            out.result     <= '0;
            out.store_data <= '0;
            out.flags      <= '0;
        end else if (advance) begin
            out.pc         <= pc;
            out.instr      <= instr;
            out.iset       <= instr_set;
            out.result     <= alu_result;
            out.store_data <= store_data;
            out.flags      <= alu_flags;
        end
    end

endmodule

`default_nettype wire

//--- source/mem_if.sv
// Data RAM bus with combinational read; a write takes effect on the clock edge while we is high
`timescale 1ns/1ps
`default_nettype none

interface mem_if #(
    parameter int MEM_ADDR_W = 6
);

    logic [MEM_ADDR_W-1:0]        addr;
    logic [cpu12_pkg::WORD_W-1:0] wdata;
    logic                         we;
    logic [cpu12_pkg::WORD_W-1:0] rdata;

    modport ctrl (output addr, wdata, we, input rdata);
    modport ram (input addr, wdata, we, output rdata);

endinterface

`default_nettype wire

//--- source/stage_if.sv
// Execute to memory stage state of one instruction; result is the RAM address for loads and stores
`timescale 1ns/1ps
`default_nettype none

interface stage_if;

    logic [cpu12_pkg::WORD_W-1:0] pc;
    logic [cpu12_pkg::WORD_W-1:0] instr;
    cpu12_pkg::iset_e             iset;
    // ALU value, or memory address for LD/ST
    logic [cpu12_pkg::WORD_W-1:0] result;
    logic [cpu12_pkg::WORD_W-1:0] store_data;
    logic [cpu12_pkg::FLAG_W-1:0] flags;

    // Execute latch side
    modport src (
        output pc, instr, iset, result, store_data, flags
    );

    // Memory stage side
    modport dst (
        input pc, instr, iset, result, store_data, flags
    );

endinterface

`default_nettype wire

//--- source/cpu12_pkg.sv
// Shared widths, instruction sets and opcodes; opcode values must match the decoder feeding the back end
`default_nettype none

package cpu12_pkg;

    // Data, pc and instruction word width
    localparam int WORD_W = 12;

    // Flag vector width and bit positions
    localparam int FLAG_W = 4;
    localparam int FLAG_Z = 0;
    localparam int FLAG_N = 1;
    localparam int FLAG_C = 2;
    localparam int FLAG_V = 3;

    // Instruction set tag that travels with every instruction
    typedef enum logic [3:0] {
        ISET_R = 4'd0,
        ISET_I = 4'd1
    } iset_e;

    // R-set opcodes, taken from instruction bits 11 to 8
    typedef enum logic [3:0] {
        OPC_R_NOP = 4'd0,
        OPC_R_ADD = 4'd1,
        OPC_R_SUB = 4'd2,
        OPC_R_AND = 4'd3,
        OPC_R_OR  = 4'd4,
        OPC_R_XOR = 4'd5,
        OPC_R_LD  = 4'd6,
        OPC_R_ST  = 4'd7
    } opc_r_e;

    // I-set opcodes, same field; immediate sits in bits 7 to 0
    typedef enum logic [3:0] {
        OPC_I_ADDI = 4'd0,
        OPC_I_ANDI = 4'd1,
        OPC_I_LDI  = 4'd2,
        OPC_I_STI  = 4'd3
    } opc_i_e;

endpackage

`default_nettype wire
